/* dv/id_stage_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_sva import id_pipe_pkg::*; (
	input wire         clk_i,
	input wire         arst_n_i,
	input wire issue_t issue_o,
	input wire         issue_valid_o,
	input wire         issue_ready_i,
	input wire         redirect_valid_o
);

	// stalled packet holds
	hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		issue_valid_o && !issue_ready_i |=> $stable(issue_o))
		else $error("issue_o changed while stalled");

	pulse_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		redirect_valid_o |=> !redirect_valid_o)
		else $error("redirect_valid_o high for two cycles");

	// first cycle out of reset
	reset_a: assert property (@(posedge clk_i)
		arst_n_i && !$past(arst_n_i) |-> !issue_valid_o && !redirect_valid_o)
		else $error("valid output high right after reset");

endmodule

bind id_stage id_stage_sva sva_inst (.clk_i(clk_i), .arst_n_i(arst_n_i), .issue_o(issue_o),
	.issue_valid_o(issue_valid_o), .issue_ready_i(issue_ready_i),
	.redirect_valid_o(redirect_valid_o));

`default_nettype wire

/* dv/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module tb_id_stage import mips_isa_pkg::*, id_pipe_pkg::*;;

	logic                clk_i = 1'b0;
	logic                arst_n_i;
	fetch_t              fetch_i;
	logic                fetch_valid_i;
	logic                fetch_ready_o;
	issue_t              issue_o;
	logic                issue_valid_o;
	logic                issue_ready_i;
	redirect_t           redirect_o;
	logic                redirect_valid_o;
	reg_wr_t             ex_fwd_i;
	reg_wr_t             mem_fwd_i;
	reg_wr_t             wb_i;

	logic [`ID_XLEN-1:0] shadow [`ID_NREGS]; // mirror of the register file
	logic [15:0]         lfsr = 16'd63137;
	issue_t              got;
	logic                got_redir;
	logic [`ID_XLEN-1:0] got_target;
	int                  mismatches = 0;
	int                  errors = 0;

	id_stage id_stage_inst (.clk_i(clk_i), .arst_n_i(arst_n_i), .fetch_i(fetch_i),
		.fetch_valid_i(fetch_valid_i), .fetch_ready_o(fetch_ready_o), .issue_o(issue_o),
		.issue_valid_o(issue_valid_o), .issue_ready_i(issue_ready_i), .redirect_o(redirect_o),
		.redirect_valid_o(redirect_valid_o), .ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i),
		.wb_i(wb_i));

	always #20 clk_i = ~clk_i;

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic get_rand(input int nbits, output logic [31:0] r);
		int i;
		r = '0;
		for (i = 0; i < nbits; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] enc_i(input major_op_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		enc_i = {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input funct_e fn);
		enc_r = {6'b000000, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] br_target(input logic [31:0] pc, input logic [15:0] off);
		br_target = pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_issue(input string name, input alu_op_e op, input alu_sel_e sel,
		input logic [31:0] r1, input logic [31:0] r2, input logic [4:0] wd, input logic wreg);
		check({name, ".aluop"}, 32'(op), 32'(got.aluop));
		check({name, ".alusel"}, 32'(sel), 32'(got.alusel));
		check({name, ".reg1"}, r1, got.reg1);
		check({name, ".reg2"}, r2, got.reg2);
		check({name, ".wd"}, 32'(wd), 32'(got.wd));
		check({name, ".wreg"}, 32'(wreg), 32'(got.wreg));
		check({name, ".link"}, 32'h0, got.link_addr); // no link outside jal / jalr
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		@(negedge clk_i);
		wb_i = '{we: 1'b1, addr: addr, data: data};
		@(negedge clk_i);
		wb_i = '0;
		if (addr != 5'd0)
			shadow[addr] = data;
	endtask

	// one instruction through the input handshake, result left in got
	task automatic issue_inst(input logic [31:0] pc, input logic [31:0] inst);
		int n;
		@(negedge clk_i);
		fetch_i = '{pc: pc, inst: inst};
		fetch_valid_i = 1'b1;
		n = 0;
		while (!fetch_ready_o && n < 20) begin
			@(negedge clk_i);
			n++;
		end
		if (!fetch_ready_o) begin
			$display("timeout: fetch_ready_o never went high");
			errors++;
		end
		@(negedge clk_i); // accepted on the edge just passed
		fetch_valid_i = 1'b0;
		n = 0;
		while (!issue_valid_o && n < 20) begin
			@(negedge clk_i);
			n++;
		end
		if (!issue_valid_o) begin
			$display("timeout: issue_valid_o never went high");
			errors++;
		end
		got = issue_o;
		got_redir = redirect_valid_o;
		got_target = redirect_o.target;
	endtask

	task automatic test_imm();
		major_op_e   ops [8];
		alu_op_e     exp_op [8];
		alu_sel_e    exp_sel [8];
		logic [31:0] r;
		logic [31:0] val;
		logic [31:0] exp2;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		int          i;
		ops = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
		exp_op = '{ALU_OR, ALU_AND, ALU_XOR, ALU_OR, ALU_ADDI, ALU_ADDIU, ALU_SLT, ALU_SLTU};
		exp_sel = '{SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_ARITH, SEL_ARITH,
			SEL_ARITH, SEL_ARITH};
		for (i = 0; i < 8; i++) begin
			get_rand(5, r);
			rs = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
			get_rand(32, val);
			write_reg(rs, val);
			get_rand(5, r);
			rt = r[4:0];
			get_rand(16, r);
			imm = r[15:0];
			if (ops[i] inside {OP_ORI, OP_ANDI, OP_XORI})
				exp2 = {16'h0000, imm};
			else if (ops[i] == OP_LUI)
				exp2 = {imm, 16'h0000};
			else
				exp2 = {{16{imm[15]}}, imm};
			issue_inst(32'h0000_1000 + 32'(i * 4), enc_i(ops[i], rs, rt, imm));
			check_issue($sformatf("imm_%s", ops[i].name()), exp_op[i], exp_sel[i], shadow[rs],
				exp2, rt, 1'b1);
		end
	endtask

	task automatic test_reg();
		funct_e      fns [16];
		alu_op_e     exp_op [16];
		alu_sel_e    exp_sel [16];
		logic [31:0] r;
		logic [31:0] val;
		logic [4:0]  rd;
		logic [4:0]  sh;
		int          i;
		fns = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
			FN_SLTU, FN_SLLV, FN_SRLV, FN_SRAV, FN_SLL, FN_SRL, FN_SRA};
		exp_op = '{ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
			ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLL, ALU_SRL, ALU_SRA};
		exp_sel = '{SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_ARITH, SEL_ARITH,
			SEL_ARITH, SEL_ARITH, SEL_ARITH, SEL_ARITH, SEL_SHIFT, SEL_SHIFT, SEL_SHIFT,
			SEL_SHIFT, SEL_SHIFT, SEL_SHIFT};
		get_rand(32, val);
		write_reg(5'd12, val);
		get_rand(32, val);
		write_reg(5'd13, val);
		for (i = 0; i < 16; i++) begin
			get_rand(5, r);
			rd = r[4:0];
			get_rand(5, r);
			sh = r[4:0];
			if (i < 13) begin
				issue_inst(32'h0000_2000, enc_r(5'd12, 5'd13, rd, 5'd0, fns[i]));
				check_issue($sformatf("reg_%s", fns[i].name()), exp_op[i], exp_sel[i],
					shadow[12], shadow[13], rd, 1'b1);
			end else begin
				issue_inst(32'h0000_2000, enc_r(5'd0, 5'd13, rd, sh, fns[i]));
				check_issue($sformatf("reg_%s", fns[i].name()), exp_op[i], exp_sel[i],
					32'(sh), shadow[13], rd, 1'b1);
			end
		end
		write_reg(5'd0, 32'hdead_beef); // r0 stays zero
		issue_inst(32'h0000_2004, enc_r(5'd0, 5'd0, 5'd7, 5'd0, FN_OR));
		check_issue("reg_r0", ALU_OR, SEL_LOGIC, 32'h0, 32'h0, 5'd7, 1'b1);
		issue_inst(32'h0000_2008, 32'hfc00_1234);
		check({"reg_unknown", ".aluop"}, 32'(ALU_NOP), 32'(got.aluop));
		check({"reg_unknown", ".alusel"}, 32'(SEL_NOP), 32'(got.alusel));
		check({"reg_unknown", ".wreg"}, 32'h0, 32'(got.wreg));
		check({"reg_unknown", ".redirect"}, 32'h0, 32'(got_redir));
	endtask

	task automatic test_forward();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		get_rand(32, a);
		write_reg(5'd5, a);
		get_rand(32, a);
		write_reg(5'd6, a);
		get_rand(32, a);
		get_rand(32, b);
		get_rand(32, c);
		ex_fwd_i = '{we: 1'b1, addr: 5'd5, data: a};
		mem_fwd_i = '{we: 1'b1, addr: 5'd5, data: b};
		issue_inst(32'h0000_3000, enc_r(5'd5, 5'd6, 5'd8, 5'd0, FN_ADDU));
		check_issue("fwd_ex_wins", ALU_ADDU, SEL_ARITH, a, shadow[6], 5'd8, 1'b1);
		ex_fwd_i = '{we: 1'b0, addr: 5'd5, data: a};
		mem_fwd_i = '{we: 1'b1, addr: 5'd6, data: c};
		issue_inst(32'h0000_3004, enc_r(5'd5, 5'd6, 5'd8, 5'd0, FN_ADDU));
		check_issue("fwd_mem_only", ALU_ADDU, SEL_ARITH, shadow[5], c, 5'd8, 1'b1);
		ex_fwd_i = '{we: 1'b1, addr: 5'd6, data: a};
		mem_fwd_i = '0;
		issue_inst(32'h0000_3008, enc_i(OP_ORI, 5'd5, 5'd6, 16'h5a5a));
		check_issue("fwd_imm_kept", ALU_OR, SEL_LOGIC, shadow[5], 32'h0000_5a5a, 5'd6, 1'b1);
		ex_fwd_i = '0;
	endtask

	task automatic check_branch(input string name, input logic [31:0] pc,
		input logic [31:0] inst, input logic exp_taken, input logic [31:0] exp_target);
		issue_inst(pc, inst);
		check({name, ".alusel"}, 32'(SEL_JUMP), 32'(got.alusel));
		check({name, ".redirect"}, 32'(exp_taken), 32'(got_redir));
		if (exp_taken)
			check({name, ".target"}, exp_target, got_target);
	endtask

	task automatic test_branch();
		logic [31:0] pc;
		logic [31:0] r;
		logic [31:0] pc4;
		logic [15:0] off;
		get_rand(32, r);
		write_reg(5'd3, r);
		write_reg(5'd4, r);
		write_reg(5'd5, r ^ 32'h1);
		write_reg(5'd6, 32'h0000_0100);
		write_reg(5'd7, 32'h0);
		write_reg(5'd8, 32'h8000_0000);
		get_rand(32, r);
		pc = {r[31:2], 2'b00};
		pc4 = pc + 32'd4;
		get_rand(16, r);
		off = r[15:0];
		check_branch("beq_taken", pc, enc_i(OP_BEQ, 5'd3, 5'd4, off), 1'b1, br_target(pc, off));
		check_branch("beq_not", pc, enc_i(OP_BEQ, 5'd3, 5'd5, off), 1'b0, 32'h0);
		check_branch("bne_taken", pc, enc_i(OP_BNE, 5'd3, 5'd5, off), 1'b1, br_target(pc, off));
		check_branch("bne_not", pc, enc_i(OP_BNE, 5'd3, 5'd4, off), 1'b0, 32'h0);
		check_branch("bgtz_taken", pc, enc_i(OP_BGTZ, 5'd6, 5'd0, off), 1'b1, br_target(pc, off));
		check_branch("bgtz_not", pc, enc_i(OP_BGTZ, 5'd7, 5'd0, off), 1'b0, 32'h0);
		check_branch("blez_taken", pc, enc_i(OP_BLEZ, 5'd8, 5'd0, off), 1'b1, br_target(pc, off));
		check_branch("blez_not", pc, enc_i(OP_BLEZ, 5'd6, 5'd0, off), 1'b0, 32'h0);
		get_rand(26, r);
		check_branch("j", pc, {OP_J, r[25:0]}, 1'b1, {pc4[31:28], r[25:0], 2'b00});
		check_branch("jal", pc, {OP_JAL, r[25:0]}, 1'b1, {pc4[31:28], r[25:0], 2'b00});
		check("jal.wd", 32'd31, 32'(got.wd));
		check("jal.wreg", 32'h1, 32'(got.wreg));
		check("jal.link", pc + 32'd8, got.link_addr);
		check_branch("jr", pc, enc_r(5'd6, 5'd0, 5'd0, 5'd0, FN_JR), 1'b1, shadow[6]);
		check("jr.wreg", 32'h0, 32'(got.wreg));
		check_branch("jalr", pc, enc_r(5'd6, 5'd0, 5'd9, 5'd0, FN_JALR), 1'b1, shadow[6]);
		check("jalr.wd", 32'd9, 32'(got.wd));
		check("jalr.link", pc + 32'd8, got.link_addr);
		// delay slot after the taken jalr
		issue_inst(pc + 32'd4, enc_i(OP_ORI, 5'd0, 5'd1, 16'h0001));
		check("ds_first", 32'h1, 32'(got.in_delayslot));
		issue_inst(pc + 32'd8, enc_i(OP_ORI, 5'd0, 5'd1, 16'h0002));
		check("ds_second", 32'h0, 32'(got.in_delayslot));
	endtask

	task automatic test_backpressure();
		issue_t held;
		int     n;
		issue_inst(32'h0000_4000, enc_i(OP_ORI, 5'd3, 5'd10, 16'h00f0));
		issue_ready_i = 1'b0; // first packet now sits in the output register
		held = got;
		check_issue("bp_first", ALU_OR, SEL_LOGIC, shadow[3], 32'h0000_00f0, 5'd10, 1'b1);
		fetch_i = '{pc: 32'h0000_4004, inst: enc_i(OP_XORI, 5'd4, 5'd11, 16'h8001)};
		fetch_valid_i = 1'b1;
		repeat (3) begin
			@(negedge clk_i);
			if (fetch_ready_o) begin
				$display("fetch_ready_o is high while the stalled output is full");
				errors++;
			end
			if (issue_o !== held) begin
				$display("mismatch bp_hold: expected %h, actual %h", held, issue_o);
				mismatches++;
			end
		end
		issue_ready_i = 1'b1;
		n = 0;
		while (issue_o === held && n < 20) begin
			@(negedge clk_i);
			n++;
		end
		fetch_valid_i = 1'b0;
		if (issue_o === held) begin
			$display("timeout: second instruction never issued after release");
			errors++;
		end
		got = issue_o;
		check_issue("bp_second", ALU_XOR, SEL_LOGIC, shadow[4], 32'h0000_8001, 5'd11, 1'b1);
	endtask

	initial begin
		for (int i = 0; i < `ID_NREGS; i++)
			shadow[i] = '0;
		arst_n_i = 1'b0;
		fetch_i = '0;
		fetch_valid_i = 1'b0;
		issue_ready_i = 1'b1;
		ex_fwd_i = '0;
		mem_fwd_i = '0;
		wb_i = '0;
		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		arst_n_i = 1'b1;
		test_imm();
		test_reg();
		test_forward();
		test_branch();
		test_backpressure();
		repeat (2) @(negedge clk_i);
		$display("mismatches: %0d, other errors: %0d", mismatches, errors);
		if (mismatches == 0 && errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/mips_isa_pkg.sv
logic/id_pipe_pkg.sv
logic/reg_file.sv
logic/inst_decoder.sv
logic/operand_mux.sv
logic/branch_unit.sv
logic/issue_reg.sv
logic/id_stage.sv
dv/id_stage_sva.sv
dv/tb_id_stage.sv

/* logic/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module branch_unit import id_pipe_pkg::*; (
	input  wire dec_t           dec_i,
	input  wire [`ID_XLEN-1:0]  pc_i,
	input  wire [`ID_XLEN-1:0]  reg1_i,
	input  wire [`ID_XLEN-1:0]  reg2_i,
	output logic                taken_o,
	output logic [`ID_XLEN-1:0] target_o,
	output logic [`ID_XLEN-1:0] link_addr_o
);

	logic [`ID_XLEN-1:0] pc_plus_4;
	logic [`ID_XLEN-1:0] pc_plus_8;
	logic [`ID_XLEN-1:0] br_target;
	logic                reg1_zero;

	assign pc_plus_4 = pc_i + `ID_XLEN'd4;
	assign pc_plus_8 = pc_i + `ID_XLEN'd8;
	assign br_target = pc_plus_4 + dec_i.imm; // imm holds offset << 2
	assign reg1_zero = (reg1_i == '0);

	always_comb begin
		taken_o = 1'b0;
		target_o = '0;
		case (dec_i.br_kind)
			BR_BEQ: taken_o = (reg1_i == reg2_i);
			BR_BNE: taken_o = (reg1_i != reg2_i);
			BR_BGTZ: taken_o = !reg1_i[`ID_XLEN-1] && !reg1_zero;
			BR_BLEZ: taken_o = reg1_i[`ID_XLEN-1] || reg1_zero;
			BR_JUMP_IMM, BR_JUMP_REG: taken_o = 1'b1;
			default: taken_o = 1'b0;
		endcase
		if (taken_o) begin
			case (dec_i.br_kind)
				BR_JUMP_IMM: target_o = {pc_plus_4[`ID_XLEN-1:28], dec_i.imm[27:0]}; // same 256MB region
				BR_JUMP_REG: target_o = reg1_i;
				default: target_o = br_target;
			endcase
		end
	end

	// jal / jalr return past the delay slot
	assign link_addr_o = dec_i.link ? pc_plus_8 : '0;

endmodule

`default_nettype wire

/* logic/id_pipe_pkg.sv */
`default_nettype none

`include "id_settings.svh"

package id_pipe_pkg;

	typedef enum logic [4:0] {
		ALU_NOP = 5'd0,
		ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_ADDI, ALU_ADDIU,
		ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
		ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP = 3'd0,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_ARITH,
		SEL_JUMP
	} alu_sel_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ,
		BR_BNE,
		BR_BGTZ,
		BR_BLEZ,
		BR_JUMP_IMM,
		BR_JUMP_REG
	} br_kind_e;

	typedef struct packed {
		logic [`ID_XLEN-1:0] pc;
		logic [`ID_XLEN-1:0] inst;
	} fetch_t;

	// execute / memory forward and write-back port
	typedef struct packed {
		logic                  we;
		logic [`ID_REG_AW-1:0] addr;
		logic [`ID_XLEN-1:0]   data;
	} reg_wr_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		br_kind_e              br_kind;
		logic [`ID_REG_AW-1:0] rs;
		logic [`ID_REG_AW-1:0] rt;
		logic [`ID_REG_AW-1:0] rd_w;
		logic                  wreg;
		logic                  rs_read;
		logic                  rt_read;
		logic                  link;
		logic [`ID_XLEN-1:0]   imm; // operand immediate, or branch displacement
	} dec_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic [`ID_XLEN-1:0]   reg1;
		logic [`ID_XLEN-1:0]   reg2;
		logic [`ID_REG_AW-1:0] wd;
		logic                  wreg;
		logic [`ID_XLEN-1:0]   link_addr;
		logic                  in_delayslot;
	} issue_t;

	typedef struct packed {
		logic [`ID_XLEN-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire

/* logic/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data path and address width
`define ID_XLEN 32

// register file geometry
`define ID_REG_AW 5
`define ID_NREGS 32

`define ID_LINK_REG 31 // jal destination

// 16-bit immediate and 26-bit jump index
`define ID_IMM_W 16
`define ID_JIDX_W 26

`endif

/* logic/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module id_stage import id_pipe_pkg::*; (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  wire fetch_t fetch_i,
	input  wire         fetch_valid_i,
	output logic        fetch_ready_o,
	output issue_t      issue_o,
	output logic        issue_valid_o,
	input  wire         issue_ready_i,
	output redirect_t   redirect_o,
	output logic        redirect_valid_o,
	input  wire reg_wr_t ex_fwd_i,
	input  wire reg_wr_t mem_fwd_i,
	input  wire reg_wr_t wb_i
);

	dec_t                dec;
	issue_t              issue_d;
	logic [`ID_XLEN-1:0] rd_data_a;
	logic [`ID_XLEN-1:0] rd_data_b;
	logic [`ID_XLEN-1:0] reg1;
	logic [`ID_XLEN-1:0] reg2;
	logic [`ID_XLEN-1:0] target;
	logic [`ID_XLEN-1:0] link_addr;
	logic                taken;
	logic                ready;
	logic                fire;

	assign fire = fetch_valid_i && ready;
	assign fetch_ready_o = ready;

	assign issue_d = '{aluop: dec.aluop, alusel: dec.alusel, reg1: reg1, reg2: reg2,
		wd: dec.rd_w, wreg: dec.wreg, link_addr: link_addr, in_delayslot: 1'b0};

	reg_file u_reg_file (.clk_i(clk_i), .arst_n_i(arst_n_i), .wr_i(wb_i),
		.rd_addr_a_i(dec.rs), .rd_addr_b_i(dec.rt),
		.rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b));

	inst_decoder u_inst_decoder (.inst_i(fetch_i.inst), .dec_o(dec));

	operand_mux u_operand_mux (.dec_i(dec), .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b),
		.ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i), .reg1_o(reg1), .reg2_o(reg2));

	branch_unit u_branch_unit (.dec_i(dec), .pc_i(fetch_i.pc), .reg1_i(reg1), .reg2_i(reg2),
		.taken_o(taken), .target_o(target), .link_addr_o(link_addr));

	issue_reg u_issue_reg (.clk_i(clk_i), .arst_n_i(arst_n_i), .fire_i(fire),
		.issue_d_i(issue_d), .taken_i(taken), .target_i(target),
		.issue_ready_i(issue_ready_i), .issue_o(issue_o), .issue_valid_o(issue_valid_o),
		.redirect_o(redirect_o), .redirect_valid_o(redirect_valid_o), .ready_o(ready));

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module inst_decoder import mips_isa_pkg::*, id_pipe_pkg::*; (
	input  wire [`ID_XLEN-1:0] inst_i,
	output dec_t               dec_o
);

	major_op_e                op;
	funct_e                   fn;
	logic [`ID_IMM_W-1:0]     imm16;
	logic [`ID_XLEN-1:0]      imm_sext;
	logic [`ID_XLEN-1:0]      br_disp;

	assign op = major_op_e'(inst_i[31:26]);
	assign fn = funct_e'(inst_i[5:0]);
	assign imm16 = inst_i[`ID_IMM_W-1:0];
	assign imm_sext = {{(`ID_XLEN-`ID_IMM_W){imm16[`ID_IMM_W-1]}}, imm16};
	assign br_disp = {imm_sext[`ID_XLEN-3:0], 2'b00}; // offset in words

	function automatic alu_op_e funct_op(input funct_e f);
		case (f)
			FN_AND: funct_op = ALU_AND;
			FN_OR: funct_op = ALU_OR;
			FN_XOR: funct_op = ALU_XOR;
			FN_NOR: funct_op = ALU_NOR;
			FN_SLL, FN_SLLV: funct_op = ALU_SLL;
			FN_SRL, FN_SRLV: funct_op = ALU_SRL;
			FN_SRA, FN_SRAV: funct_op = ALU_SRA;
			FN_ADD: funct_op = ALU_ADD;
			FN_ADDU: funct_op = ALU_ADDU;
			FN_SUB: funct_op = ALU_SUB;
			FN_SUBU: funct_op = ALU_SUBU;
			FN_SLT: funct_op = ALU_SLT;
			FN_SLTU: funct_op = ALU_SLTU;
			FN_JR: funct_op = ALU_JR;
			FN_JALR: funct_op = ALU_JALR;
			default: funct_op = ALU_NOP;
		endcase
	endfunction

	function automatic alu_sel_e funct_sel(input funct_e f);
		case (f)
			FN_AND, FN_OR, FN_XOR, FN_NOR: funct_sel = SEL_LOGIC;
			FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: funct_sel = SEL_SHIFT;
			FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: funct_sel = SEL_ARITH;
			FN_JR, FN_JALR: funct_sel = SEL_JUMP;
			default: funct_sel = SEL_NOP;
		endcase
	endfunction

	always_comb begin
		dec_o = '0; // nop record
		dec_o.rs = inst_i[25:21];
		dec_o.rt = inst_i[20:16];
		dec_o.rd_w = inst_i[15:11];
		case (op)
			OP_SPECIAL: begin
				dec_o.aluop = funct_op(fn);
				dec_o.alusel = funct_sel(fn);
				dec_o.rs_read = (dec_o.aluop != ALU_NOP);
				dec_o.rt_read = (dec_o.aluop != ALU_NOP) && (dec_o.alusel != SEL_JUMP);
				dec_o.wreg = (dec_o.aluop != ALU_NOP) && (fn != FN_JR);
				case (fn)
					FN_SLL, FN_SRL, FN_SRA: begin
						dec_o.rs_read = 1'b0; // shamt goes on reg1
						dec_o.imm = {{(`ID_XLEN-5){1'b0}}, inst_i[10:6]};
					end
					FN_JR: dec_o.br_kind = BR_JUMP_REG;
					FN_JALR: begin
						dec_o.br_kind = BR_JUMP_REG;
						dec_o.link = 1'b1;
					end
					default: ;
				endcase
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				dec_o.rs_read = 1'b1;
				dec_o.wreg = 1'b1;
				dec_o.rd_w = inst_i[20:16];
				dec_o.alusel = SEL_ARITH;
				dec_o.imm = imm_sext;
				case (op)
					OP_ORI, OP_LUI: dec_o.aluop = ALU_OR;
					OP_ANDI: dec_o.aluop = ALU_AND;
					OP_XORI: dec_o.aluop = ALU_XOR;
					OP_ADDI: dec_o.aluop = ALU_ADDI;
					OP_ADDIU: dec_o.aluop = ALU_ADDIU;
					OP_SLTI: dec_o.aluop = ALU_SLT;
					default: dec_o.aluop = ALU_SLTU;
				endcase
				if (op == OP_LUI) begin
					dec_o.alusel = SEL_LOGIC;
					dec_o.imm = {imm16, {(`ID_XLEN-`ID_IMM_W){1'b0}}};
				end else if (op inside {OP_ORI, OP_ANDI, OP_XORI}) begin
					dec_o.alusel = SEL_LOGIC;
					dec_o.imm = {{(`ID_XLEN-`ID_IMM_W){1'b0}}, imm16};
				end
			end
			OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
				dec_o.alusel = SEL_JUMP;
				dec_o.rs_read = 1'b1;
				dec_o.rt_read = (op == OP_BEQ) || (op == OP_BNE);
				dec_o.imm = br_disp;
				case (op)
					OP_BEQ: {dec_o.aluop, dec_o.br_kind} = {ALU_BEQ, BR_BEQ};
					OP_BNE: {dec_o.aluop, dec_o.br_kind} = {ALU_BNE, BR_BNE};
					OP_BGTZ: {dec_o.aluop, dec_o.br_kind} = {ALU_BGTZ, BR_BGTZ};
					default: {dec_o.aluop, dec_o.br_kind} = {ALU_BLEZ, BR_BLEZ};
				endcase
			end
			OP_J, OP_JAL: begin
				dec_o.alusel = SEL_JUMP;
				dec_o.br_kind = BR_JUMP_IMM;
				dec_o.aluop = (op == OP_JAL) ? ALU_JAL : ALU_J;
				dec_o.wreg = (op == OP_JAL);
				dec_o.link = (op == OP_JAL);
				dec_o.rd_w = (op == OP_JAL) ? `ID_REG_AW'(`ID_LINK_REG) : inst_i[15:11];
				dec_o.imm = {4'b0000, inst_i[`ID_JIDX_W-1:0], 2'b00};
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/issue_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module issue_reg import id_pipe_pkg::*; (
	input  wire                 clk_i,
	input  wire                 arst_n_i,
	input  wire                 fire_i,
	input  wire issue_t         issue_d_i, // in_delayslot is filled in here
	input  wire                 taken_i,
	input  wire [`ID_XLEN-1:0]  target_i,
	input  wire                 issue_ready_i,
	output issue_t              issue_o,
	output logic                issue_valid_o,
	output redirect_t           redirect_o,
	output logic                redirect_valid_o,
	output logic                ready_o
);

	logic ds_q; // next accepted inst sits in a delay slot

	assign ready_o = !issue_valid_o || issue_ready_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			issue_o <= '0;
			issue_valid_o <= 1'b0;
			redirect_o <= '0;
			redirect_valid_o <= 1'b0;
			ds_q <= 1'b0;
		end else begin
			redirect_valid_o <= fire_i && taken_i; // single pulse
			if (fire_i) begin
				issue_o <= issue_d_i;
				issue_o.in_delayslot <= ds_q;
				issue_valid_o <= 1'b1;
				ds_q <= taken_i;
				if (taken_i)
					redirect_o.target <= target_i;
			end else if (issue_ready_i) begin
				issue_valid_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	// major opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} major_op_e;

	// special function code, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

endpackage

`default_nettype wire

/* logic/operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module operand_mux import id_pipe_pkg::*; (
	input  wire dec_t            dec_i,
	input  wire [`ID_XLEN-1:0]   rd_data_a_i,
	input  wire [`ID_XLEN-1:0]   rd_data_b_i,
	input  wire reg_wr_t         ex_fwd_i,
	input  wire reg_wr_t         mem_fwd_i,
	output logic [`ID_XLEN-1:0]  reg1_o,
	output logic [`ID_XLEN-1:0]  reg2_o
);

	// execute beats memory beats the register file
	function automatic logic [`ID_XLEN-1:0] pick(
		input logic                  rd_en,
		input logic [`ID_REG_AW-1:0] addr,
		input logic [`ID_XLEN-1:0]   file_data,
		input logic [`ID_XLEN-1:0]   imm,
		input reg_wr_t               ex,
		input reg_wr_t               mem
	);
		if (!rd_en)
			pick = imm;
		else if (ex.we && ex.addr == addr)
			pick = ex.data;
		else if (mem.we && mem.addr == addr)
			pick = mem.data;
		else
			pick = file_data;
	endfunction

	assign reg1_o = pick(dec_i.rs_read, dec_i.rs, rd_data_a_i, dec_i.imm, ex_fwd_i, mem_fwd_i);
	assign reg2_o = pick(dec_i.rt_read, dec_i.rt, rd_data_b_i, dec_i.imm, ex_fwd_i, mem_fwd_i);

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module reg_file import id_pipe_pkg::*; (
	input  wire                  clk_i,
	input  wire                  arst_n_i,
	input  wire reg_wr_t         wr_i,
	input  wire [`ID_REG_AW-1:0] rd_addr_a_i,
	input  wire [`ID_REG_AW-1:0] rd_addr_b_i,
	output logic [`ID_XLEN-1:0]  rd_data_a_o,
	output logic [`ID_XLEN-1:0]  rd_data_b_o
);

	logic [`ID_XLEN-1:0] regs [`ID_NREGS];
	logic                wr_en;

	assign wr_en = wr_i.we && (wr_i.addr != '0); // r0 is hardwired

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `ID_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	// same-cycle write goes straight to the read port
	assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 :
		(wr_en && wr_i.addr == rd_addr_a_i) ? wr_i.data : regs[rd_addr_a_i];
	assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 :
		(wr_en && wr_i.addr == rd_addr_b_i) ? wr_i.data : regs[rd_addr_b_i];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the id_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_id_stage \
	-f files.f \
	-o sim_id_stage

out=$(./obj_dir/sim_id_stage)
echo "$out"

# pass only if the pass message was printed
echo "$out" | grep -qF '** PASS **'
